//--- sources.f
+incdir+source
source/data_mem_pkg.sv
source/core_bram_bridge.sv
source/bram_byte_we.sv
source/data_mem_top.sv
testbench/data_mem_chk.sv
testbench/data_mem_tb.sv

//--- testbench/data_mem_tb.sv
`timescale 1ns/1ps
`include "data_mem_macros.svh"

module data_mem_tb;

  import data_mem_pkg::*;

  localparam int MEM_DEPTH = 64;
  localparam int N_TABLE   = 12;
  localparam int N_BURST   = 16;
  localparam int N_ALL     = N_TABLE + N_BURST;
  localparam int CLK_PER   = 4;
  // reset, clear sweep, four cycles per request plus slack
  localparam int MAX_CYCLES = 8 + MEM_DEPTH + 4 * N_ALL + 50;

  typedef struct packed {
    logic                     we;
    logic [`DATA_MEM_BEW-1:0] be;
    logic [`DATA_MEM_AW-1:0]  addr;
    logic [`DATA_MEM_DW-1:0]  wdata;
    logic [`DATA_MEM_DW-1:0]  exp_rdata;
    logic                     exp_err;
    // expected values come from the shadow memory
    logic                     use_model;
  } test_entry_t;

  logic     clk;
  logic     reset;
  logic     req_i;
  mem_req_t req_data_i;
  logic     gnt_o;
  logic     rvalid_o;
  mem_rsp_t rsp_o;

  test_entry_t             tests [N_ALL];
  logic [`DATA_MEM_DW-1:0] shadow [MEM_DEPTH];
  int                      seed = 32'h25ecccc9;
  int                      n_tests;

  // one response can be in flight
  logic                    pending;
  logic [`DATA_MEM_DW-1:0] pend_rdata;
  logic                    pend_err;

  data_mem_top #(
    .MEM_DEPTH  (MEM_DEPTH)
  ) UUT (
    .clk        (clk),
    .reset      (reset),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .gnt_o      (gnt_o),
    .rvalid_o   (rvalid_o),
    .rsp_o      (rsp_o)
  );

  always #2 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic add_entry(input logic we, input logic [3:0] be, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp_rdata,
                           input logic exp_err, input logic use_model);
    tests[n_tests].we        = we;
    tests[n_tests].be        = be;
    tests[n_tests].addr      = addr;
    tests[n_tests].wdata     = wdata;
    tests[n_tests].exp_rdata = exp_rdata;
    tests[n_tests].exp_err   = exp_err;
    tests[n_tests].use_model = use_model;
    n_tests++;
  endtask

  // write then read the same word, in back to back cycles
  task automatic add_burst;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] wdata;
    for (int k = 0; k < N_BURST / 2; k++) begin
      r     = $random(seed);
      addr  = {27'd0, r[2:0], 2'b00};
      wdata = $random(seed);
      add_entry(1'b1, r[11:8], addr, wdata, 32'h0, 1'b0, 1'b1);
      add_entry(1'b0, 4'h0, addr, 32'h0, 32'h0, 1'b0, 1'b1);
    end
  endtask

  task automatic drive_request(input test_entry_t t);
    req_i            = 1'b1;
    req_data_i.we    = t.we;
    req_data_i.be    = t.be;
    req_data_i.addr  = t.addr;
    req_data_i.wdata = t.wdata;
  endtask

  // sampled at the falling edge, rvalid belongs to the previous grant
  task automatic check_response;
    if (pending) begin
      if (!rvalid_o) begin
        abort_run("rvalid_o missing one cycle after a granted request");
      end
      check_value("rsp_o.rdata", rsp_o.rdata, pend_rdata);
      check_value("rsp_o.err", {31'd0, rsp_o.err}, {31'd0, pend_err});
      pending = 1'b0;
    end else if (rvalid_o) begin
      abort_run("rvalid_o seen without a granted request");
    end
  endtask

  task automatic record_grant(input test_entry_t t);
    int unsigned word;
    logic        in_range;
    word     = t.addr >> 2;
    in_range = (word < MEM_DEPTH);
    if (t.use_model) begin
      pend_err   = ~in_range;
      pend_rdata = (in_range && !t.we) ? shadow[word] : 32'h0;
    end else begin
      pend_err   = t.exp_err;
      pend_rdata = t.exp_rdata;
    end
    // byte merge for in range stores
    if (in_range && t.we) begin
      for (int b = 0; b < 4; b++) begin
        if (t.be[b]) begin
          shadow[word][b*8 +: 8] = t.wdata[b*8 +: 8];
        end
      end
    end
    pending = 1'b1;
  endtask

  initial begin
    #(MAX_CYCLES * CLK_PER);
    abort_run("timeout, the test sequence did not finish in time");
  end

  // a failing protocol assertion in the bound checker ends the run
  always @(UUT.u_chk.n_failed) begin
    if (UUT.u_chk.n_failed != 0) begin
      abort_run("protocol assertion failed in the bound checker");
    end
  end

  initial begin
    int waits;
    clk        = 1'b0;
    reset      = 1'b1;
    req_i      = 1'b0;
    req_data_i = '0;
    pending    = 1'b0;
    pend_rdata = '0;
    pend_err   = 1'b0;
    n_tests    = 0;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      shadow[i] = '0;
    end

    //        we    be    addr          wdata         rdata         err
    add_entry(1'b0, 4'h0, 32'h0000_0014, 32'h0,        32'h0,        1'b0, 1'b0);
    add_entry(1'b1, 4'hf, 32'h0000_0020, 32'hdeadbeef, 32'h0,        1'b0, 1'b0);
    add_entry(1'b0, 4'h0, 32'h0000_0020, 32'h0,        32'hdeadbeef, 1'b0, 1'b0);
    add_entry(1'b1, 4'hf, 32'h0000_0000, 32'h11223344, 32'h0,        1'b0, 1'b0);
    add_entry(1'b1, 4'h5, 32'h0000_0000, 32'haabbccdd, 32'h0,        1'b0, 1'b0);
    add_entry(1'b0, 4'h0, 32'h0000_0000, 32'h0,        32'h11bb33dd, 1'b0, 1'b0);
    add_entry(1'b1, 4'ha, 32'h0000_0020, 32'h55667788, 32'h0,        1'b0, 1'b0);
    // low address bits are ignored
    add_entry(1'b0, 4'h0, 32'h0000_0022, 32'h0,        32'h55ad77ef, 1'b0, 1'b0);
    add_entry(1'b1, 4'hf, 32'h0000_0100, 32'hffffffff, 32'h0,        1'b1, 1'b0);
    add_entry(1'b0, 4'h0, 32'h8000_0000, 32'h0,        32'h0,        1'b1, 1'b0);
    add_entry(1'b0, 4'h0, 32'h0000_0000, 32'h0,        32'h11bb33dd, 1'b0, 1'b0);
    add_entry(1'b0, 4'h0, 32'h0000_00fc, 32'h0,        32'h0,        1'b0, 1'b0);
    add_burst();

    // first request is already pending through reset
    drive_request(tests[0]);

    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int i = 0; i < n_tests; i++) begin
      drive_request(tests[i]);
      waits = 0;
      @(negedge clk);
      check_response();
      while (!gnt_o) begin
        waits++;
        @(negedge clk);
        check_response();
      end
      // only the clear sweep may hold off a request
      if (i == 0) begin
        check_value("gnt_o wait cycles", waits, MEM_DEPTH);
      end else begin
        check_value("gnt_o wait cycles", waits, 0);
      end
      record_grant(tests[i]);
      @(posedge clk);
      #1;
    end

    req_i      = 1'b0;
    req_data_i = '0;
    @(negedge clk);
    check_response();
    @(negedge clk);
    check_response();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- testbench/data_mem_chk.sv
`timescale 1ns/1ps

module data_mem_chk (
  input logic                   clk,
  input logic                   reset,
  input logic                   req_i,
  input data_mem_pkg::mem_req_t req_data_i,
  input logic                   gnt_i,
  input logic                   rvalid_i,
  input data_mem_pkg::mem_rsp_t rsp_i,
  input logic                   busy_i
);

  logic accept;

  // number of failed assertions
  int unsigned n_failed = 0;

  assign accept = req_i & gnt_i;

  // one rvalid per accepting edge, on the next edge
  a_rvalid_follows : assert property (@(posedge clk) disable iff (reset) accept |=> rvalid_i)
    else begin
      $error("rvalid_o missing after an accepted request");
      n_failed++;
    end

  a_rvalid_only : assert property (@(posedge clk) disable iff (reset) !accept |=> !rvalid_i)
    else begin
      $error("rvalid_o without an accepted request");
      n_failed++;
    end

  // no grant through reset and the clear sweep
  a_gnt_blocked : assert property (@(posedge clk) (reset || busy_i) |-> !gnt_i)
    else begin
      $error("gnt_o high during reset or BRAM busy");
      n_failed++;
    end

  a_err_valid : assert property (@(posedge clk) rsp_i.err |-> rvalid_i)
    else begin
      $error("rsp_o.err high without rvalid_o");
      n_failed++;
    end

  // core holds its request until granted
  a_req_stable : assert property (@(posedge clk) disable iff (reset)
                                  (req_i && !gnt_i) |=> $stable(req_data_i))
    else begin
      $error("req_data_i changed while waiting for grant");
      n_failed++;
    end

endmodule

bind data_mem_top data_mem_chk u_chk (
  .clk        (clk),
  .reset      (reset),
  .req_i      (req_i),
  .req_data_i (req_data_i),
  .gnt_i      (gnt_o),
  .rvalid_i   (rvalid_o),
  .rsp_i      (rsp_o),
  .busy_i     (bram_busy)
);

//--- source/data_mem_top.sv
`timescale 1ns/1ps
`include "data_mem_macros.svh"

module data_mem_top #(
  parameter int MEM_DEPTH = `DATA_MEM_DEPTH
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_i,
  input  data_mem_pkg::mem_req_t req_data_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output data_mem_pkg::mem_rsp_t rsp_o
);

  import data_mem_pkg::*;

  // bridge to BRAM command
  bram_port_t              bram_cmd;

  // BRAM back to bridge
  logic                    bram_busy;
  logic [`DATA_MEM_DW-1:0] bram_dout;

  core_bram_bridge #(
    .MEM_DEPTH   (MEM_DEPTH)
  ) u_bridge (
    .clk         (clk),
    .reset       (reset),
    .req_i       (req_i),
    .core_req_i  (req_data_i),
    .gnt_o       (gnt_o),
    .rvalid_o    (rvalid_o),
    .rsp_o       (rsp_o),
    .bram_o      (bram_cmd),
    .bram_busy_i (bram_busy),
    .bram_dout_i (bram_dout)
  );

  // single port data memory, cleared after reset
  bram_byte_we #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_bram (
    .clk       (clk),
    .reset     (reset),
    .port_i    (bram_cmd),
    .busy_o    (bram_busy),
    .dout_o    (bram_dout)
  );

endmodule

//--- source/bram_byte_we.sv
`timescale 1ns/1ps
`include "data_mem_macros.svh"

module bram_byte_we #(
  parameter int MEM_DEPTH = `DATA_MEM_DEPTH
) (
  input  logic                     clk,
  input  logic                     reset,
  input  data_mem_pkg::bram_port_t port_i,
  output logic                     busy_o,
  output logic [`DATA_MEM_DW-1:0]  dout_o
);

  localparam int IDX_W  = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
  localparam int BYTE_W = `DATA_MEM_DW / `DATA_MEM_BEW;

  // last word index of the clear sweep
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(MEM_DEPTH - 1);

  logic [`DATA_MEM_DW-1:0] mem [MEM_DEPTH];

  logic [IDX_W-1:0] sweep_idx;
  logic             busy_q;
  logic [IDX_W-1:0] acc_idx;

  // bridge only enables the port for in range words
  assign acc_idx = port_i.addr[IDX_W-1:0];

  // sweep counter is loaded in reset and walks every word once
  // busy drops on the edge that clears the last word
  always_ff @(posedge clk) begin
    if (reset) begin
      sweep_idx <= '0;
      busy_q    <= 1'b1;
    end else if (busy_q) begin
      sweep_idx <= sweep_idx + 1'b1;
      if (sweep_idx == LAST_IDX) begin
        busy_q <= 1'b0;
      end
    end
  end

  // storage and read port
  // read first, dout holds the word as it was before this edge
  always_ff @(posedge clk) begin
    if (busy_q) begin
      mem[sweep_idx] <= '0;
    end else if (port_i.en) begin
      dout_o <= mem[acc_idx];
      for (int b = 0; b < `DATA_MEM_BEW; b++) begin
        if (port_i.web[b]) begin
          mem[acc_idx][b*BYTE_W +: BYTE_W] <= port_i.din[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  assign busy_o = busy_q;

endmodule

//--- source/core_bram_bridge.sv
`timescale 1ns/1ps
`include "data_mem_macros.svh"

module core_bram_bridge #(
  parameter int MEM_DEPTH = `DATA_MEM_DEPTH
) (
  input  logic                     clk,
  input  logic                     reset,

  // core side
  input  logic                     req_i,
  input  data_mem_pkg::mem_req_t   core_req_i,
  output logic                     gnt_o,
  output logic                     rvalid_o,
  output data_mem_pkg::mem_rsp_t   rsp_o,

  // BRAM side
  output data_mem_pkg::bram_port_t bram_o,
  input  logic                     bram_busy_i,
  input  logic [`DATA_MEM_DW-1:0]  bram_dout_i
);

  import data_mem_pkg::*;

  // depth as an address sized value for the range compare
  localparam logic [`DATA_MEM_AW-1:0] DEPTH_W = MEM_DEPTH;

  logic                    accept;
  logic                    in_range;
  logic                    is_write;
  logic [`DATA_MEM_AW-1:0] word_idx;

  // response stage
  logic                    rvalid_q;
  logic                    err_q;
  logic                    rd_q;
  mem_rsp_t                rsp_d;

  // no grant in reset or during the BRAM clear sweep
  // busy is unknown before the first reset edge
  assign gnt_o  = req_i & ~reset & ~bram_busy_i;
  assign accept = req_i & gnt_o;

  // byte address to word index, low two bits dropped
  assign word_idx = {2'b00, core_req_i.addr[`DATA_MEM_AW-1:2]};
  assign in_range = (word_idx < DEPTH_W);
  assign is_write = core_req_i.we;

  // out of range requests are granted but never touch the BRAM
  always_comb begin
    bram_o.en   = accept & in_range;
    bram_o.web  = '0;
    bram_o.addr = word_idx;
    bram_o.din  = core_req_i.wdata;
    if (bram_o.en && is_write) begin
      bram_o.web = core_req_i.be;
    end
  end

  // one cycle from the accepting edge to rvalid
  // BRAM read data lines up with this stage
  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      rd_q     <= 1'b0;
    end else begin
      rvalid_q <= accept;
      err_q    <= accept & ~in_range;
      rd_q     <= accept & in_range & ~is_write;
    end
  end

  // load data only for in range reads
  always_comb begin
    rsp_d.err   = err_q;
    rsp_d.rdata = '0;
    if (rd_q) begin
      rsp_d.rdata = bram_dout_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rsp_o    = rsp_d;

endmodule

//--- source/data_mem_pkg.sv
`include "data_mem_macros.svh"

package data_mem_pkg;

  // load or store from the core
  // held stable until the bridge grants it
  typedef struct packed {
    // high for a store
    logic                     we;
    // byte lanes touched by a store
    logic [`DATA_MEM_BEW-1:0] be;
    // byte address, two low bits ignored
    logic [`DATA_MEM_AW-1:0]  addr;
    logic [`DATA_MEM_DW-1:0]  wdata;
  } mem_req_t;

  // response to the core, valid with rvalid only
  typedef struct packed {
    // load data, zero for stores and errors
    logic [`DATA_MEM_DW-1:0] rdata;
    // address was beyond the memory depth
    logic                    err;
  } mem_rsp_t;

  // command for one BRAM port
  typedef struct packed {
    // port enable for reads and writes
    logic                     en;
    // byte write enables, all zero on a read
    logic [`DATA_MEM_BEW-1:0] web;
    // word index, not a byte address
    logic [`DATA_MEM_AW-1:0]  addr;
    logic [`DATA_MEM_DW-1:0]  din;
  } bram_port_t;

endpackage

//--- source/data_mem_macros.svh
`ifndef DATA_MEM_MACROS_SVH
`define DATA_MEM_MACROS_SVH

// data path width of the core and the BRAM
`define DATA_MEM_DW 32

// core address width, byte addressed
`define DATA_MEM_AW 32

// one write enable per byte lane
`define DATA_MEM_BEW 4

// default number of words in the data memory
`define DATA_MEM_DEPTH 1024

`endif
